//--- tb.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/ctrl_exc_detect.sv
rtl/ctrl_irq_select.sv
rtl/ctrl_fsm.sv
rtl/core_ctrl.sv
verification/tb_clk_gen.sv
verification/tb_core_ctrl.sv

//--- Makefile
# Verilator build and run for the core controller testbench

VERILATOR  ?= verilator
TOP        ?= tb_core_ctrl
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
BUILD_ARGS ?= --binary -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(BUILD_ARGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_core_ctrl.sv
/*
 * Testbench for the core controller.
 * Boot, table-driven exceptions, branches and interrupts, then NMI, MIE and WFI sequences.
 */
`timescale 1ns/1ps

module tb_core_ctrl import ctrl_pkg::*; ();

  localparam int RedirectTimeout = 20;
  localparam int ResetTimeout    = 20;

  // decoder flag patterns with illegal in the msb
  localparam insn_flags_t FL_NONE       = 7'b000_0000;
  localparam insn_flags_t FL_ILLEGAL    = 7'b100_0000;
  localparam insn_flags_t FL_ECALL      = 7'b010_0000;
  localparam insn_flags_t FL_MRET       = 7'b001_0000;
  localparam insn_flags_t FL_WFI        = 7'b000_1000;
  localparam insn_flags_t FL_EBRK       = 7'b000_0100;
  localparam insn_flags_t FL_FETCH_ERR  = 7'b000_0010;
  localparam insn_flags_t FL_FETCH_ERR2 = 7'b000_0011;

  // csr strobes as {save_if, save_id, restore_mret, save_cause}
  localparam logic [3:0] ST_NONE = 4'b0000;
  localparam logic [3:0] ST_EXC  = 4'b0101;
  localparam logic [3:0] ST_IRQ  = 4'b1001;
  localparam logic [3:0] ST_MRET = 4'b0010;

  typedef struct packed {
    insn_flags_t flags;
    instr_info_t info;
    priv_lvl_e   priv;
    irq_req_t    irq;
    logic [1:0]  jump_branch;
    int          stall_cycles;
    int          exp_latency;
    pc_sel_e     exp_mux;
    logic [3:0]  exp_strobes;
    logic [5:0]  exp_cause;
    logic [31:0] exp_mtval;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        instr_valid;
  insn_flags_t insn_flags;
  instr_info_t instr_info;
  logic        branch_set;
  logic        jump_set;
  irq_req_t    irq;
  priv_lvl_e   priv_mode;
  logic        mstatus_tw;
  logic        stall;
  logic        instr_req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  csr_ctrl_t   csr;
  logic        nmi_mode;
  logic        ctrl_busy;
  logic        id_in_ready;
  logic        instr_valid_clear;

  entry_t entries[$];
  string  names[$];

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  core_ctrl dut_i (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .fetch_enable_i      (fetch_enable),
    .instr_valid_i       (instr_valid),
    .insn_flags_i        (insn_flags),
    .instr_info_i        (instr_info),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .irq_i               (irq),
    .priv_mode_i         (priv_mode),
    .mstatus_tw_i        (mstatus_tw),
    .stall_i             (stall),
    .instr_req_o         (instr_req),
    .pc_set_o            (pc_set),
    .pc_mux_o            (pc_mux),
    .csr_o               (csr),
    .nmi_mode_o          (nmi_mode),
    .ctrl_busy_o         (ctrl_busy),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                                  $time, what, got, exp));
    end
  endtask

  function automatic irq_req_t irq_vec(input logic nmi, input logic [14:0] fast,
                                       input logic ext, input logic sw,
                                       input logic tmr, input logic mie);
    return {nmi, fast, ext, sw, tmr, mie};
  endfunction

  function automatic instr_info_t make_info(input logic [31:0] instr,
                                            input logic [15:0] instr_c,
                                            input logic is_c, input logic [31:0] pc);
    return {instr, instr_c, is_c, pc};
  endfunction

  function automatic entry_t make_entry(input insn_flags_t flags, input instr_info_t info,
                                        input priv_lvl_e priv, input irq_req_t irq_in,
                                        input logic [1:0] jump_branch, input int stall_cycles,
                                        input int latency, input pc_sel_e mux,
                                        input logic [3:0] strobes, input logic [5:0] cause,
                                        input logic [31:0] mtval);
    entry_t e;
    e.flags        = flags;
    e.info         = info;
    e.priv         = priv;
    e.irq          = irq_in;
    e.jump_branch  = jump_branch;
    e.stall_cycles = stall_cycles;
    e.exp_latency  = latency;
    e.exp_mux      = mux;
    e.exp_strobes  = strobes;
    e.exp_cause    = cause;
    e.exp_mtval    = mtval;
    return e;
  endfunction

  // ID stage back to idle while fetch enable and tw keep their value
  task automatic clear_inputs();
    instr_valid <= 1'b0;
    insn_flags  <= FL_NONE;
    instr_info  <= '0;
    branch_set  <= 1'b0;
    jump_set    <= 1'b0;
    irq         <= '0;
    priv_mode   <= PRIV_LVL_M;
    stall       <= 1'b0;
  endtask

  // caller sits at the falling edge of the cycle the stimulus went in
  task automatic wait_redirect(input string what, input int stall_cycles, output int cycles);
    cycles = 0;
    while (!pc_set && cycles < RedirectTimeout) begin
      if (cycles < stall_cycles) begin
        check_value({what, ": id_in_ready_o under stall"}, 32'(id_in_ready), 32'd0);
        check_value({what, ": instr_valid_clear_o under stall"},
                    32'(instr_valid_clear), 32'd0);
      end
      @(posedge clk);
      cycles++;
      if (cycles == stall_cycles) begin
        stall <= 1'b0;
      end
      @(negedge clk);
    end
    if (!pc_set) begin
      stop_with_failure($sformatf("timeout: no pc_set_o seen for %s", what));
    end
  endtask

  task automatic check_redirect(input string what, input pc_sel_e mux,
                                input logic [3:0] strobes, input logic [5:0] cause,
                                input logic [31:0] mtval);
    check_value({what, ": pc_mux_o"}, 32'(pc_mux), 32'(mux));
    check_value({what, ": csr strobes"},
                32'({csr.save_if, csr.save_id, csr.restore_mret, csr.save_cause}),
                32'(strobes));
    check_value({what, ": cause"}, 32'(csr.cause), 32'(cause));
    check_value({what, ": mtval"}, csr.mtval, mtval);
    // a redirect drops the instruction held in ID
    check_value({what, ": instr_valid_clear_o"}, 32'(instr_valid_clear), 32'd1);
  endtask

  task automatic run_entry(input entry_t e, input string what);
    int cycles;
    @(posedge clk);
    insn_flags  <= e.flags;
    instr_info  <= e.info;
    instr_valid <= 1'b1;
    priv_mode   <= e.priv;
    irq         <= e.irq;
    branch_set  <= e.jump_branch[0];
    jump_set    <= e.jump_branch[1];
    stall       <= (e.stall_cycles > 0);
    @(negedge clk);
    wait_redirect(what, e.stall_cycles, cycles);
    check_value({what, ": redirect latency"}, 32'(cycles), 32'(e.exp_latency));
    check_redirect(what, e.exp_mux, e.exp_strobes, e.exp_cause, e.exp_mtval);
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic add_entry(input string what, input entry_t e);
    entries.push_back(e);
    names.push_back(what);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] w;
    logic [31:0] pc;
    logic [15:0] wc;
    irq_req_t    none;
    none = '0;
    w  = $urandom();
    pc = $urandom();
    wc = 16'($urandom());
    add_entry("illegal 32-bit", make_entry(FL_ILLEGAL, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h02, w));
    // compressed mtval is the 16-bit word zero-extended
    add_entry("illegal compressed", make_entry(FL_ILLEGAL, make_info(w, wc, 1'b1, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h02, {16'h0000, wc}));
    add_entry("mret in U-mode", make_entry(FL_MRET, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_U, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h02, w));
    add_entry("wfi in U-mode with tw", make_entry(FL_WFI, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_U, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h02, w));
    w  = $urandom();
    pc = $urandom();
    add_entry("ecall in M-mode", make_entry(FL_ECALL, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h0B, 32'h0));
    add_entry("ecall in U-mode", make_entry(FL_ECALL, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_U, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h08, 32'h0));
    add_entry("ebreak", make_entry(FL_EBRK, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h03, 32'h0));
    add_entry("fetch error", make_entry(FL_FETCH_ERR, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h01, pc));
    add_entry("fetch error plus2", make_entry(FL_FETCH_ERR2, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_EXC, ST_EXC, 6'h01, pc + 32'd2));
    // taken branch and jump redirect in the same cycle
    add_entry("branch", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b01, 0, 0, PC_JUMP, ST_NONE, 6'h00, 32'h0));
    add_entry("jump", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b10, 0, 0, PC_JUMP, ST_NONE, 6'h00, 32'h0));
    add_entry("branch with fetch error", make_entry(FL_FETCH_ERR, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b01, 0, 1, PC_EXC, ST_EXC, 6'h01, pc));
    add_entry("mret in M-mode", make_entry(FL_MRET, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, none, 2'b00, 0, 1, PC_ERET, ST_MRET, 6'h00, 32'h0));
    // interrupt priority with the highest fast line first
    add_entry("fast 14 over the rest", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h4A21, 1'b1, 1'b1, 1'b1, 1'b1), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h3E, 32'h0));
    add_entry("fast 8 over timer", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h0124, 1'b0, 1'b0, 1'b1, 1'b1), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h38, 32'h0));
    add_entry("external", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h0, 1'b1, 1'b1, 1'b1, 1'b1), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h2B, 32'h0));
    add_entry("software", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h0, 1'b0, 1'b1, 1'b1, 1'b1), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h23, 32'h0));
    add_entry("timer", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h0, 1'b0, 1'b0, 1'b1, 1'b1), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h27, 32'h0));
    // held off for 3 stalled cycles
    add_entry("external under stall", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b0, 15'h0, 1'b1, 1'b0, 1'b0, 1'b1), 2'b00, 3, 4,
              PC_EXC, ST_IRQ, 6'h2B, 32'h0));
    // nmi ignores mie and stays last since it enters NMI mode
    add_entry("nmi over all lines", make_entry(FL_NONE, make_info(w, wc, 1'b0, pc),
              PRIV_LVL_M, irq_vec(1'b1, 15'h7FFF, 1'b1, 1'b1, 1'b1, 1'b0), 2'b00, 0, 1,
              PC_EXC, ST_IRQ, 6'h3F, 32'h0));
  endtask

  ////////////////////////////////////////////////////////////
  // directed sequences
  ////////////////////////////////////////////////////////////

  task automatic wait_for_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < ResetTimeout) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      stop_with_failure("reset was never released by the clock generator");
    end
  endtask

  task automatic boot_sequence();
    int n;
    repeat (3) begin
      @(negedge clk);
      check_value("instr_req_o before fetch enable", 32'(instr_req), 32'd0);
    end
    @(posedge clk);
    fetch_enable <= 1'b1;
    @(negedge clk);
    @(negedge clk);
    // BOOT_SET
    check_value("boot pc_set_o", 32'(pc_set), 32'd1);
    check_value("boot pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check_value("boot instr_req_o", 32'(instr_req), 32'd1);
    n = 0;
    while (pc_set && n < RedirectTimeout) begin
      @(negedge clk);
      n++;
    end
    if (pc_set) begin
      stop_with_failure("controller never left the boot PC set");
    end
    @(negedge clk);
    check_value("id_in_ready_o in DECODE", 32'(id_in_ready), 32'd1);
    check_value("instr_req_o in DECODE", 32'(instr_req), 32'd1);
  endtask

  task automatic check_nmi_mode();
    @(negedge clk);
    check_value("nmi_mode_o after nmi", 32'(nmi_mode), 32'd1);
    @(posedge clk);
    irq <= irq_vec(1'b1, 15'h0, 1'b0, 1'b0, 1'b0, 1'b1);
    repeat (6) begin
      @(negedge clk);
      check_value("second nmi in NMI mode", 32'(pc_set), 32'd0);
    end
    @(posedge clk);
    clear_inputs();
    run_entry(make_entry(FL_MRET, make_info(32'h30200073, 16'h0, 1'b0, 32'h0000_0100),
              PRIV_LVL_M, '0, 2'b00, 0, 1, PC_ERET, ST_MRET, 6'h00, 32'h0), "mret from nmi");
    @(negedge clk);
    check_value("nmi_mode_o after mret", 32'(nmi_mode), 32'd0);
  endtask

  task automatic check_mie_masking();
    @(posedge clk);
    irq <= irq_vec(1'b0, 15'h7FFF, 1'b1, 1'b1, 1'b1, 1'b0);
    repeat (6) begin
      @(negedge clk);
      check_value("interrupt with mie clear", 32'(pc_set), 32'd0);
    end
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic check_wfi_sleep();
    int n;
    @(posedge clk);
    insn_flags  <= FL_WFI;
    instr_valid <= 1'b1;
    instr_info  <= make_info($urandom(), 16'h0, 1'b0, $urandom());
    n = 0;
    @(negedge clk);
    while (ctrl_busy && n < RedirectTimeout) begin
      @(negedge clk);
      n++;
    end
    if (ctrl_busy) begin
      stop_with_failure("ctrl_busy_o never dropped after wfi");
    end
    // wfi leaves ID once the core is asleep
    @(posedge clk);
    clear_inputs();
    repeat (6) begin
      @(negedge clk);
      check_value("ctrl_busy_o while asleep", 32'(ctrl_busy), 32'd0);
    end
    @(posedge clk);
    irq <= irq_vec(1'b0, 15'h0, 1'b1, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    check_value("ctrl_busy_o on wake-up", 32'(ctrl_busy), 32'd1);
    wait_redirect("wake-up interrupt", 0, n);
    check_redirect("wake-up interrupt", PC_EXC, ST_IRQ, 6'h2B, 32'h0);
    @(posedge clk);
    clear_inputs();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb5d7));
    fetch_enable <= 1'b0;
    mstatus_tw   <= 1'b1;
    clear_inputs();
    build_table();
    wait_for_reset();
    boot_sequence();
    foreach (entries[i]) begin
      run_entry(entries[i], names[i]);
    end
    check_nmi_mode();
    check_mie_masking();
    check_wfi_sleep();
    $display("test passed");
    $finish;
  end

endmodule

//--- verification/tb_clk_gen.sv
/*
 * Clock and reset source for the controller testbench.
 * 40 ns clock, active-low reset held for the first 4 rising edges.
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 20;
  localparam int ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // release lines up with a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- rtl/core_ctrl.sv
/*
 * Core controller top level.
 * Connects exception detect, interrupt select and the controller FSM.
 */
`timescale 1ns/1ps

module core_ctrl import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  insn_flags_t insn_flags_i,
  input  instr_info_t instr_info_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  irq_req_t    irq_i,
  input  priv_lvl_e   priv_mode_i,
  input  logic        mstatus_tw_i,
  input  logic        stall_i,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output csr_ctrl_t   csr_o,
  output logic        nmi_mode_o,
  output logic        ctrl_busy_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o
);

  exc_req_t   exc_req;
  exc_cause_e irq_cause;
  logic       in_flush;
  logic       handle_irq;
  logic       irq_pending;
  logic       irq_taken;
  logic       mret_done;

  ctrl_exc_detect u_exc_detect (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .insn_flags_i,
    .priv_mode_i,
    .mstatus_tw_i,
    .in_flush_i (in_flush),
    .exc_req_o  (exc_req)
  );

  ctrl_irq_select u_irq_select (
    .clk_i,
    .rst_ni,
    .irq_i,
    .irq_taken_i   (irq_taken),
    .mret_done_i   (mret_done),
    .handle_irq_o  (handle_irq),
    .irq_pending_o (irq_pending),
    .irq_cause_o   (irq_cause),
    .nmi_mode_o
  );

  // nmi line feeds SLEEP wake-up directly
  ctrl_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .fetch_enable_i,
    .instr_valid_i,
    .exc_req_i     (exc_req),
    .instr_info_i,
    .priv_mode_i,
    .branch_set_i,
    .jump_set_i,
    .stall_i,
    .handle_irq_i  (handle_irq),
    .irq_cause_i   (irq_cause),
    .nmi_pending_i (irq_i.nmi),
    .irq_pending_i (irq_pending),
    .in_flush_o    (in_flush),
    .irq_taken_o   (irq_taken),
    .mret_done_o   (mret_done),
    .instr_req_o,
    .pc_set_o,
    .pc_mux_o,
    .csr_o,
    .ctrl_busy_o,
    .id_in_ready_o,
    .instr_valid_clear_o
  );

endmodule

//--- rtl/ctrl_fsm.sv
/*
 * Main controller state machine.
 * Drives PC redirects, CSR save strobes and the ID stall and flush controls.
 */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_fsm import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  exc_req_t    exc_req_i,
  input  instr_info_t instr_info_i,
  input  priv_lvl_e   priv_mode_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_i,
  input  logic        handle_irq_i,
  input  exc_cause_e  irq_cause_i,
  input  logic        nmi_pending_i,
  input  logic        irq_pending_i,
  output logic        in_flush_o,
  output logic        irq_taken_o,
  output logic        mret_done_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output csr_ctrl_t   csr_o,
  output logic        ctrl_busy_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o
);

  ctrl_fsm_e state_q;
  ctrl_fsm_e state_d;
  logic      halt_if;
  logic      flush_id;

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b1;
    pc_set_o    = 1'b0;
    // mux only matters while pc_set_o is high
    pc_mux_o    = PC_BOOT;
    csr_o       = '0;
    ctrl_busy_o = 1'b1;
    halt_if     = 1'b0;
    flush_id    = 1'b0;
    irq_taken_o = 1'b0;
    mret_done_o = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold the boot pc until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending line, mie does not matter here
        if (nmi_pending_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait out the IF miss
        if (!stall_i) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        pc_mux_o = PC_JUMP;
        // keep the instruction in ID for FLUSH to inspect
        if (exc_req_i.special_req) begin
          state_d = FLUSH;
          halt_if = 1'b1;
        end
        // a fetch error beats the branch target
        if ((branch_set_i || jump_set_i) && instr_valid_i && !exc_req_i.fetch_err) begin
          pc_set_o = 1'b1;
        end
        // irq waits for a multicycle instruction to finish
        if (handle_irq_i && stall_i) begin
          halt_if = 1'b1;
        end
        if (handle_irq_i && !stall_i && !exc_req_i.special_req) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o = PC_EXC;
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          irq_taken_o      = 1'b1;
          csr_o.save_if    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = irq_cause_i;
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_req_i.exc_req_q) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;
          // priority per the privileged spec exception table
          if (exc_req_i.fetch_err) begin
            csr_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
            csr_o.mtval = exc_req_i.fetch_err_plus2 ?
                          instr_info_i.pc + `CTRL_XLEN'(2) : instr_info_i.pc;
          end else if (exc_req_i.illegal_q) begin
            csr_o.cause = EXC_CAUSE_ILLEGAL_INSN;
            csr_o.mtval = instr_info_i.is_compressed ?
                          {{(`CTRL_XLEN - `CTRL_ILEN_C){1'b0}}, instr_info_i.instr_c} :
                          instr_info_i.instr;
          end else if (exc_req_i.ecall) begin
            csr_o.cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                        EXC_CAUSE_ECALL_UMODE;
          end else begin
            // ebreak, no debug mode so always a trap
            csr_o.cause = EXC_CAUSE_BREAKPOINT;
          end
        end else if (exc_req_i.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_o.restore_mret = 1'b1;
          mret_done_o        = 1'b1;
        end else if (exc_req_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stall and flush
  ////////////////////////////////////////////////////////////

  assign in_flush_o = (state_q == FLUSH);

  // halt_if keeps the ID instruction valid unless it is flushed too
  assign id_in_ready_o       = ~stall_i & ~halt_if;
  assign instr_valid_clear_o = ~(stall_i | halt_if) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  state_legal_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN}
  );

  // a FLUSH redirect always updates the CSR file
  flush_redirect_csr_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (in_flush_o && pc_set_o) |-> (csr_o.save_cause || csr_o.restore_mret)
  );

endmodule

//--- rtl/ctrl_irq_select.sv
/*
 * Interrupt take decision and priority encoder.
 * Also keeps the NMI-mode flag that blocks nested interrupts.
 */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_irq_select import ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  irq_req_t   irq_i,
  input  logic       irq_taken_i,
  input  logic       mret_done_i,
  output logic       handle_irq_o,
  output logic       irq_pending_o,
  output exc_cause_e irq_cause_o,
  output logic       nmi_mode_o
);

  logic [3:0] fast_id;
  logic       nmi_mode_q;

  // any enabled maskable line, also used to leave SLEEP
  assign irq_pending_o = (|irq_i.fast) | irq_i.external | irq_i.software | irq_i.timer;

  // nothing is taken inside an NMI handler
  assign handle_irq_o = ~nmi_mode_q & (irq_i.nmi | (irq_pending_o & irq_i.mstatus_mie));

  // highest fast index wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int unsigned i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (irq_i.fast[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // cause priority
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (irq_i.nmi) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (|irq_i.fast) begin
      // interrupt bit plus 16, then the line index
      irq_cause_o = exc_cause_e'({2'b11, fast_id});
    end else if (irq_i.external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_i.software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // enter on a taken NMI, leave on mret
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_taken_i && (irq_cause_o == EXC_CAUSE_IRQ_NM)) begin
      nmi_mode_q <= 1'b1;
    end else if (mret_done_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

  // the FSM only takes what this block asked for
  taken_needs_handle_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_taken_i |-> handle_irq_o
  );

endmodule

//--- rtl/ctrl_exc_detect.sv
/*
 * Exception detection for the ID stage instruction.
 * Qualifies decoder flags and flops the exception and illegal requests.
 */
`timescale 1ns/1ps

module ctrl_exc_detect import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  insn_flags_t insn_flags_i,
  input  priv_lvl_e   priv_mode_i,
  input  logic        mstatus_tw_i,
  input  logic        in_flush_i,
  output exc_req_t    exc_req_o
);

  logic illegal_insn;
  logic illegal_umode;
  logic illegal_d;
  logic exc_req_d;
  logic illegal_q;
  logic exc_req_q;

  // decoder flags know nothing of instr_valid
  assign illegal_insn              = insn_flags_i.illegal & instr_valid_i;
  assign exc_req_o.ecall           = insn_flags_i.ecall & instr_valid_i;
  assign exc_req_o.mret            = insn_flags_i.mret & instr_valid_i;
  assign exc_req_o.wfi             = insn_flags_i.wfi & instr_valid_i;
  assign exc_req_o.ebrk            = insn_flags_i.ebrk & instr_valid_i;
  assign exc_req_o.fetch_err       = insn_flags_i.fetch_err & instr_valid_i;
  assign exc_req_o.fetch_err_plus2 = insn_flags_i.fetch_err_plus2 & instr_valid_i;

  // mret needs M-mode, tw traps wfi below M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (exc_req_o.mret | (mstatus_tw_i & exc_req_o.wfi));

  // dropped in FLUSH so a handled request does not linger
  assign illegal_d = (illegal_insn | illegal_umode) & ~in_flush_i;

  assign exc_req_d = (exc_req_o.ecall | exc_req_o.ebrk | illegal_d | exc_req_o.fetch_err) &
                     ~in_flush_i;

  // anything that needs the FLUSH state
  assign exc_req_o.special_req = exc_req_o.mret | exc_req_o.wfi | exc_req_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_req_q <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      exc_req_q <= exc_req_d;
      illegal_q <= illegal_d;
    end
  end

  assign exc_req_o.exc_req_q = exc_req_q;
  assign exc_req_o.illegal_q = illegal_q;

  // an illegal instruction always travels as an exception request
  illegal_implies_exc_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) illegal_q |-> exc_req_q
  );

endmodule

//--- rtl/ctrl_pkg.sv
/*
 * Types shared by the core controller blocks.
 * Modules pull these in with a wildcard import in their header.
 */
`include "ctrl_defines.svh"

package ctrl_pkg;

  // fetch address selector towards the IF stage
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // mcause encodings, fast irq n sits at FAST_0 + n
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2B,
    EXC_CAUSE_IRQ_FAST_0         = 6'h30,
    EXC_CAUSE_IRQ_FAST_14        = 6'h3E,
    EXC_CAUSE_IRQ_NM             = 6'h3F
  } exc_cause_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // controller states, all eight codes are used
  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  // raw decoder flags, not yet qualified by instr_valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic fetch_err;
    logic fetch_err_plus2;
  } insn_flags_t;

  // instruction in the IF-ID register
  typedef struct packed {
    logic [`CTRL_XLEN-1:0]   instr;
    logic [`CTRL_ILEN_C-1:0] instr_c;
    logic                    is_compressed;
    logic [`CTRL_XLEN-1:0]   pc;
  } instr_info_t;

  // interrupt lines, already masked by mie
  typedef struct packed {
    logic                          nmi;
    logic [`CTRL_NUM_FAST_IRQ-1:0] fast;
    logic                          external;
    logic                          software;
    logic                          timer;
    logic                          mstatus_mie;
  } irq_req_t;

  // strobes and data towards the CSR file
  typedef struct packed {
    logic                  save_if;
    logic                  save_id;
    logic                  restore_mret;
    logic                  save_cause;
    exc_cause_e            cause;
    logic [`CTRL_XLEN-1:0] mtval;
  } csr_ctrl_t;

  // qualified requests from exception detect to the FSM
  typedef struct packed {
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic fetch_err;
    logic fetch_err_plus2;
    logic exc_req_q;
    logic illegal_q;
    logic special_req;
  } exc_req_t;

endpackage

//--- rtl/ctrl_defines.svh
/*
 * Width and count macros for the core controller.
 * Included by the package and by any RTL file that sizes logic with them.
 */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// data and pc width
`define CTRL_XLEN 32

// compressed instruction width, zero-extended into mtval
`define CTRL_ILEN_C 16

////////////////////////////////////////////////////////////
// interrupts and causes
////////////////////////////////////////////////////////////

// fast interrupt lines, highest index wins
`define CTRL_NUM_FAST_IRQ 15

// mcause width, msb flags an interrupt
`define CTRL_CAUSE_W 6

`endif
